// File: design/ecc_sram_pkg.sv
/*
 * Shared definitions of the ECC-protected SRAM. Holds the SECDED code sizes,
 * the Hsiao check matrix used by encoder and decoder, and the FSM encodings.
 * Modules refer to it by scoped names.
 */
package ecc_sram_pkg;

  localparam int unsigned DataWidth = 32;
  localparam int unsigned ParWidth  = 7;
  localparam int unsigned CodeWidth = DataWidth + ParWidth;
  localparam int unsigned ByteWidth = 8;
  localparam int unsigned BeWidth   = DataWidth / ByteWidth;

  // Syndrome column of each data bit
  // All columns have weight three and differ from each other
  // Check bit j owns the unit column with only bit j set
  localparam logic [ParWidth-1:0] HsiaoCols [DataWidth] = '{
    7'h07, 7'h0B, 7'h13, 7'h23, 7'h43, 7'h0D, 7'h15, 7'h25,
    7'h45, 7'h19, 7'h29, 7'h49, 7'h31, 7'h51, 7'h61, 7'h0E,
    7'h16, 7'h26, 7'h46, 7'h1A, 7'h2A, 7'h4A, 7'h32, 7'h52,
    7'h62, 7'h1C, 7'h2C, 7'h4C, 7'h34, 7'h54, 7'h64, 7'h38
  };

  // Front-end store FSM
  typedef enum logic [1:0] {
    ST_NORMAL, // Requests go straight to the bank
    ST_RMW,    // Merged partial store is written
    ST_FIX_WB  // Load result cycle, a single error is written back
  } store_state_e;

  // Background scrubber FSM
  typedef enum logic [1:0] {
    SC_IDLE,   // Waits for a free bank cycle
    SC_CHECK,  // Checks the word read in the previous cycle
    SC_REPAIR  // Writes the corrected word back
  } scrub_state_e;

endpackage

// File: design/secded_enc.sv
/*
 * Hsiao SECDED encoder for one 32-bit word. Purely combinational, the
 * codeword holds the data in its low bits and the check bits on top.
 */
`timescale 1ns/1ps

module secded_enc (
  input  logic [ecc_sram_pkg::DataWidth-1:0] data_i,
  output logic [ecc_sram_pkg::CodeWidth-1:0] code_o
);

  logic [ecc_sram_pkg::ParWidth-1:0] check;

  // Each data bit toggles the check bits named in its column
  always_comb begin
    check = '0;
    for (int i = 0; i < ecc_sram_pkg::DataWidth; i++) begin
      if (data_i[i]) begin
        check = check ^ ecc_sram_pkg::HsiaoCols[i];
      end
    end
  end

  assign code_o = {check, data_i}; // Check bits in [38:32]

endmodule

// File: design/secded_dec.sv
/*
 * Hsiao SECDED decoder. Recomputes the check bits, forms the syndrome,
 * corrects one flipped data bit and flags single or multiple errors.
 * Combinational, used by the front-end and by the scrubber.
 */
`timescale 1ns/1ps

module secded_dec (
  input  logic [ecc_sram_pkg::CodeWidth-1:0] code_i,
  output logic [ecc_sram_pkg::DataWidth-1:0] data_o,
  output logic [ecc_sram_pkg::ParWidth-1:0]  syndrome_o,
  output logic                               single_o,
  output logic                               multi_o
);

  logic [ecc_sram_pkg::DataWidth-1:0] data_raw;
  logic [ecc_sram_pkg::ParWidth-1:0]  check_raw;
  logic [ecc_sram_pkg::ParWidth-1:0]  check_calc;

  assign data_raw  = code_i[ecc_sram_pkg::DataWidth-1:0];
  assign check_raw = code_i[ecc_sram_pkg::CodeWidth-1:ecc_sram_pkg::DataWidth];

  // Check bits as the encoder would produce them for the stored data
  always_comb begin
    check_calc = '0;
    for (int i = 0; i < ecc_sram_pkg::DataWidth; i++) begin
      if (data_raw[i]) begin
        check_calc = check_calc ^ ecc_sram_pkg::HsiaoCols[i];
      end
    end
  end

  assign syndrome_o = check_calc ^ check_raw;

  // Odd weight points at one bit, even nonzero weight cannot be located
  assign single_o = ^syndrome_o;
  assign multi_o  = (|syndrome_o) & ~(^syndrome_o);

  // Flip the data bit whose column matches
  // A unit syndrome matches no data column, so check-bit errors pass data as is
  always_comb begin
    for (int i = 0; i < ecc_sram_pkg::DataWidth; i++) begin
      data_o[i] = data_raw[i] ^ (syndrome_o == ecc_sram_pkg::HsiaoCols[i]);
    end
  end

endmodule

// File: design/ecc_scrubber.sv
/*
 * Sits between the front-end and the bank. Front-end accesses pass through
 * unchanged, idle bank cycles are used to read words one after another,
 * check them and write back single-error repairs.
 */
`timescale 1ns/1ps

module ecc_scrubber #(
  parameter  int unsigned NumWords  = 256,
  localparam int unsigned AddrWidth = (NumWords > 1) ? $clog2(NumWords) : 1
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               scrub_trigger_i,
  input  logic                               bank_req_i,
  input  logic                               bank_we_i,
  input  logic [AddrWidth-1:0]               bank_addr_i,
  input  logic [ecc_sram_pkg::CodeWidth-1:0] bank_wdata_i,
  output logic [ecc_sram_pkg::CodeWidth-1:0] bank_rdata_o,
  output logic                               mem_req_o,
  output logic                               mem_we_o,
  output logic [AddrWidth-1:0]               mem_addr_o,
  output logic [ecc_sram_pkg::CodeWidth-1:0] mem_wdata_o,
  input  logic [ecc_sram_pkg::CodeWidth-1:0] mem_rdata_i,
  output logic                               fix_o,
  output logic                               uncorrectable_o
);

  ecc_sram_pkg::scrub_state_e state_d, state_q;

  logic [AddrWidth-1:0]               addr_d, addr_q;
  logic [AddrWidth-1:0]               addr_next;
  logic                               scrub_req;
  logic                               scrub_we;
  logic                               overwritten;
  logic [ecc_sram_pkg::DataWidth-1:0] dec_data;
  logic                               dec_single;
  logic                               dec_multi;
  logic [ecc_sram_pkg::DataWidth-1:0] fixed_q;
  logic [ecc_sram_pkg::CodeWidth-1:0] repair_code;

  secded_dec i_dec (
    .code_i     (mem_rdata_i),
    .data_o     (dec_data),
    .syndrome_o (),
    .single_o   (dec_single),
    .multi_o    (dec_multi)
  );

  secded_enc i_enc (
    .data_i (fixed_q),
    .code_o (repair_code)
  );

  assign addr_next = (addr_q == AddrWidth'(NumWords - 1)) ? '0 : addr_q + 1'b1;

  // A front-end write to the word under check makes the read data stale
  assign overwritten = bank_req_i & bank_we_i & (bank_addr_i == addr_q);

  always_comb begin
    state_d         = state_q;
    addr_d          = addr_q;
    scrub_req       = 1'b0;
    scrub_we        = 1'b0;
    fix_o           = 1'b0;
    uncorrectable_o = 1'b0;
    case (state_q)
      ecc_sram_pkg::SC_IDLE: begin
        if (scrub_trigger_i && !bank_req_i) begin
          scrub_req = 1'b1;
          state_d   = ecc_sram_pkg::SC_CHECK;
        end
      end
      ecc_sram_pkg::SC_CHECK: begin
        state_d = ecc_sram_pkg::SC_IDLE; // Stale word is read again later
        if (!overwritten) begin
          if (dec_single) begin
            fix_o   = 1'b1;
            state_d = ecc_sram_pkg::SC_REPAIR;
          end else begin
            uncorrectable_o = dec_multi;
            addr_d          = addr_next;
          end
        end
      end
      ecc_sram_pkg::SC_REPAIR: begin
        state_d = ecc_sram_pkg::SC_IDLE;
        if (!bank_req_i) begin // Yield to the front-end otherwise
          scrub_req = 1'b1;
          scrub_we  = 1'b1;
          addr_d    = addr_next;
        end
      end
      default: state_d = ecc_sram_pkg::SC_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ecc_sram_pkg::SC_IDLE;
      addr_q  <= '0;
    end else begin
      state_q <= state_d;
      addr_q  <= addr_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == ecc_sram_pkg::SC_CHECK) begin
      fixed_q <= dec_data;
    end
  end

  // Front-end always owns the port when it asks
  assign mem_req_o    = bank_req_i | scrub_req;
  assign mem_we_o     = bank_req_i ? bank_we_i : scrub_we;
  assign mem_addr_o   = bank_req_i ? bank_addr_i : addr_q;
  assign mem_wdata_o  = bank_req_i ? bank_wdata_i : repair_code;
  assign bank_rdata_o = mem_rdata_i;

  a_no_steal: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(scrub_req && bank_req_i));

endmodule

// File: design/sram_bank.sv
/*
 * Behavioral single-port memory holding one codeword per address.
 * Read data is registered and appears one cycle after the request,
 * it holds its value over writes and idle cycles. Contents start at zero.
 */
`timescale 1ns/1ps

module sram_bank #(
  parameter  int unsigned NumWords  = 256,
  localparam int unsigned AddrWidth = (NumWords > 1) ? $clog2(NumWords) : 1
) (
  input  logic                               clk_i,
  input  logic                               req_i,
  input  logic                               we_i,
  input  logic [AddrWidth-1:0]               addr_i,
  input  logic [ecc_sram_pkg::CodeWidth-1:0] wdata_i,
  output logic [ecc_sram_pkg::CodeWidth-1:0] rdata_o
);

  logic [ecc_sram_pkg::CodeWidth-1:0] mem_q [NumWords];

  initial begin
    for (int i = 0; i < NumWords; i++) begin
      mem_q[i] = '0; // All zeros is a valid codeword
    end
  end

  always @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_i && !we_i) begin
      rdata_o <= mem_q[addr_i];
    end
  end

endmodule

// File: design/ecc_sram.sv
/*
 * Top level of the ECC-protected SRAM. Encodes stores, turns partial stores
 * into a read-modify-write, decodes loads and writes corrected words back.
 * A scrubber between this front-end and the bank repairs words in idle cycles.
 */
`timescale 1ns/1ps

module ecc_sram #(
  parameter  int unsigned NumWords  = 256,
  localparam int unsigned AddrWidth = (NumWords > 1) ? $clog2(NumWords) : 1
) (
  input  logic                               clk_i,
  input  logic                               rst_ni,
  input  logic                               scrub_trigger_i,
  input  logic                               req_i,
  input  logic                               we_i,
  input  logic [AddrWidth-1:0]               addr_i,
  input  logic [ecc_sram_pkg::DataWidth-1:0] wdata_i,
  input  logic [ecc_sram_pkg::BeWidth-1:0]   be_i,
  output logic [ecc_sram_pkg::DataWidth-1:0] rdata_o,
  output logic                               gnt_o,
  output logic                               single_error_o,
  output logic                               multi_error_o,
  output logic                               scrubber_fix_o,
  output logic                               scrub_uncorrectable_o
);

  ecc_sram_pkg::store_state_e state_d, state_q;

  logic                               accept;
  logic                               partial;
  logic                               fix_wb;
  logic                               valid_read_d, valid_read_q;
  logic [AddrWidth-1:0]               addr_q;
  logic [ecc_sram_pkg::DataWidth-1:0] wdata_q;
  logic [ecc_sram_pkg::BeWidth-1:0]   be_q;
  logic [ecc_sram_pkg::DataWidth-1:0] be_mask;
  logic [ecc_sram_pkg::DataWidth-1:0] merged;
  logic [ecc_sram_pkg::DataWidth-1:0] enc_in;
  logic [ecc_sram_pkg::DataWidth-1:0] dec_data;
  logic                               dec_single;
  logic                               dec_multi;

  logic                               bank_req, bank_we;
  logic [AddrWidth-1:0]               bank_addr;
  logic [ecc_sram_pkg::CodeWidth-1:0] bank_wdata, bank_rdata;
  logic                               mem_req, mem_we;
  logic [AddrWidth-1:0]               mem_addr;
  logic [ecc_sram_pkg::CodeWidth-1:0] mem_wdata, mem_rdata;

  assign accept  = req_i & gnt_o;
  assign partial = we_i & (be_i != {ecc_sram_pkg::BeWidth{1'b1}});

  // Load result carries a correctable error, bank port goes to the write-back
  assign fix_wb = (state_q == ecc_sram_pkg::ST_FIX_WB) & dec_single;
  assign gnt_o  = (state_q != ecc_sram_pkg::ST_RMW) & ~fix_wb;

  for (genvar b = 0; b < ecc_sram_pkg::BeWidth; b++) begin : gen_be_mask
    assign be_mask[b*ecc_sram_pkg::ByteWidth +: ecc_sram_pkg::ByteWidth] =
      {ecc_sram_pkg::ByteWidth{be_q[b]}};
  end

  assign merged = (be_mask & wdata_q) | (~be_mask & dec_data); // Old bytes already corrected

  always_comb begin
    state_d   = ecc_sram_pkg::ST_NORMAL;
    bank_req  = accept;
    bank_we   = we_i & ~partial; // Partial store reads first
    bank_addr = addr_i;
    enc_in    = wdata_i;
    case (state_q)
      ecc_sram_pkg::ST_RMW: begin
        bank_req  = 1'b1;
        bank_we   = 1'b1;
        bank_addr = addr_q;
        enc_in    = merged;
      end
      ecc_sram_pkg::ST_FIX_WB: begin
        if (dec_single) begin
          bank_req  = 1'b1;
          bank_we   = 1'b1;
          bank_addr = addr_q;
          enc_in    = dec_data;
        end
      end
      default: ;
    endcase
    if (accept) begin
      if (partial) begin
        state_d = ecc_sram_pkg::ST_RMW;
      end else if (!we_i) begin
        state_d = ecc_sram_pkg::ST_FIX_WB;
      end
    end
  end

  // Error flags only mean something when the bank word was asked for
  assign valid_read_d   = accept & (~we_i | partial);
  assign single_error_o = dec_single & valid_read_q;
  assign multi_error_o  = dec_multi & valid_read_q;
  assign rdata_o        = dec_data;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= ecc_sram_pkg::ST_NORMAL;
      valid_read_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      valid_read_q <= valid_read_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      addr_q  <= addr_i;
      wdata_q <= wdata_i;
      be_q    <= be_i;
    end
  end

  secded_enc i_enc (
    .data_i (enc_in),
    .code_o (bank_wdata)
  );

  secded_dec i_dec (
    .code_i     (bank_rdata),
    .data_o     (dec_data),
    .syndrome_o (),
    .single_o   (dec_single),
    .multi_o    (dec_multi)
  );

  ecc_scrubber #(
    .NumWords (NumWords)
  ) i_scrubber (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .scrub_trigger_i (scrub_trigger_i),
    .bank_req_i      (bank_req),
    .bank_we_i       (bank_we),
    .bank_addr_i     (bank_addr),
    .bank_wdata_i    (bank_wdata),
    .bank_rdata_o    (bank_rdata),
    .mem_req_o       (mem_req),
    .mem_we_o        (mem_we),
    .mem_addr_o      (mem_addr),
    .mem_wdata_o     (mem_wdata),
    .mem_rdata_i     (mem_rdata),
    .fix_o           (scrubber_fix_o),
    .uncorrectable_o (scrub_uncorrectable_o)
  );

  sram_bank #(
    .NumWords (NumWords)
  ) i_bank (
    .clk_i   (clk_i),
    .req_i   (mem_req),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

  // Each stall covers exactly one extra bank access
  a_gnt_one_cycle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !gnt_o |=> gnt_o);

  a_err_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(single_error_o && multi_error_o));

endmodule

// File: dv/tb_ecc_sram.sv
/*
 * Directed testbench of the ECC-protected SRAM. Drives loads and stores,
 * flips bits inside the bank to check correction, write-back and scrubbing,
 * and compares results with a reference memory of plain data words.
 */
`timescale 1ns/1ps

module tb_ecc_sram;

  localparam int unsigned NumWords  = 256;
  localparam int unsigned AddrWidth = $clog2(NumWords);
  localparam int unsigned DataWidth = ecc_sram_pkg::DataWidth;
  localparam int unsigned CodeWidth = ecc_sram_pkg::CodeWidth;
  localparam int unsigned ClkPeriod = 4;
  localparam int unsigned Seed      = 32'h8f8d94ee;

  // Cycle budget of each test
  localparam int unsigned BudgetReset   = 20;
  localparam int unsigned BudgetFull    = 96;
  localparam int unsigned BudgetPartial = 64;
  localparam int unsigned BudgetSingle  = 48;
  localparam int unsigned BudgetDouble  = 16;
  localparam int unsigned BudgetScrub   = 3 * NumWords + 32;
  localparam int unsigned BudgetMixed   = 160;
  localparam int unsigned BudgetSum     = BudgetReset + BudgetFull + BudgetPartial +
                                          BudgetSingle + BudgetDouble + BudgetScrub +
                                          BudgetMixed;
  localparam int unsigned WatchdogCycles = (BudgetSum + 4 * NumWords) * 2;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             scrub_trigger_i;
  logic                             req_i;
  logic                             we_i;
  logic [AddrWidth-1:0]             addr_i;
  logic [DataWidth-1:0]             wdata_i;
  logic [ecc_sram_pkg::BeWidth-1:0] be_i;
  logic [DataWidth-1:0]             rdata_o;
  logic                             gnt_o;
  logic                             single_error_o;
  logic                             multi_error_o;
  logic                             scrubber_fix_o;
  logic                             scrub_uncorrectable_o;

  int unsigned          errors;
  logic [DataWidth-1:0] model [int unsigned]; // Expected data per address

  ecc_sram #(
    .NumWords (NumWords)
  ) i_dut (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .scrub_trigger_i       (scrub_trigger_i),
    .req_i                 (req_i),
    .we_i                  (we_i),
    .addr_i                (addr_i),
    .wdata_i               (wdata_i),
    .be_i                  (be_i),
    .rdata_o               (rdata_o),
    .gnt_o                 (gnt_o),
    .single_error_o        (single_error_o),
    .multi_error_o         (multi_error_o),
    .scrubber_fix_o        (scrubber_fix_o),
    .scrub_uncorrectable_o (scrub_uncorrectable_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  // Inputs change and outputs are sampled 1 ns after the rising edge
  task automatic step();
    @(posedge clk_i);
    #1;
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  function automatic logic [DataWidth-1:0] model_word(input int unsigned addr);
    if (model.exists(addr)) begin
      return model[addr];
    end
    return '0; // Bank starts out as zero words
  endfunction

  function automatic logic [DataWidth-1:0] byte_merge(input logic [DataWidth-1:0] old_word,
                                                      input logic [DataWidth-1:0] new_word,
                                                      input logic [3:0]           be);
    logic [DataWidth-1:0] res;
    for (int b = 0; b < 4; b++) begin
      res[b*8 +: 8] = be[b] ? new_word[b*8 +: 8] : old_word[b*8 +: 8];
    end
    return res;
  endfunction

  // Every request starts in a cycle where gnt_o must already be high
  task automatic wait_gnt();
    int unsigned waits;
    waits = 0;
    while (!gnt_o) begin
      step();
      waits++;
    end
    if (waits > 0) begin
      $display("Request waited %0d cycles for gnt_o at %0t", waits, $time);
      errors++;
    end
  endtask

  task automatic inject_flip(input int unsigned addr, input int unsigned bitpos);
    i_dut.i_bank.mem_q[addr][bitpos] = ~i_dut.i_bank.mem_q[addr][bitpos];
  endtask

  task automatic do_write(input int unsigned addr, input logic [DataWidth-1:0] data,
                          input logic [3:0] be);
    logic partial;
    partial = (be != 4'hF);
    req_i   = 1'b1;
    we_i    = 1'b1;
    addr_i  = AddrWidth'(addr);
    wdata_i = data;
    be_i    = be;
    wait_gnt();
    step(); // Accepted on this edge
    req_i      = 1'b0;
    we_i       = 1'b0;
    model[addr] = byte_merge(model_word(addr), data, be);
    check_val("gnt_o", gnt_o, !partial); // Merge cycle holds the bank
    check_val("single_error_o", single_error_o, 0);
    check_val("multi_error_o", multi_error_o, 0);
    if (partial) begin
      step();
      check_val("gnt_o", gnt_o, 1);
    end
  endtask

  task automatic do_read(input int unsigned addr, output logic [DataWidth-1:0] data,
                         output logic single, output logic multi, output logic gnt_next);
    req_i  = 1'b1;
    we_i   = 1'b0;
    addr_i = AddrWidth'(addr);
    wait_gnt();
    step();
    req_i    = 1'b0;
    data     = rdata_o;
    single   = single_error_o;
    multi    = multi_error_o;
    gnt_next = gnt_o;
  endtask

  // Clean read with data from the model and no flags
  task automatic read_expect(input int unsigned addr);
    logic [DataWidth-1:0] data;
    logic                 single, multi, gnt_next;
    do_read(addr, data, single, multi, gnt_next);
    check_val("rdata_o", data, model_word(addr));
    check_val("single_error_o", single, 0);
    check_val("multi_error_o", multi, 0);
    check_val("gnt_o", gnt_next, 1);
  endtask

  task automatic test_reset_and_full();
    int unsigned addrs [$];
    int unsigned addr;
    check_val("gnt_o", gnt_o, 1);
    check_val("single_error_o", single_error_o, 0);
    check_val("multi_error_o", multi_error_o, 0);
    check_val("scrubber_fix_o", scrubber_fix_o, 0);
    check_val("scrub_uncorrectable_o", scrub_uncorrectable_o, 0);
    for (int i = 0; i < 16; i++) begin
      addr = $urandom % NumWords;
      addrs.push_back(addr);
      do_write(addr, $urandom, 4'hF);
    end
    foreach (addrs[i]) read_expect(addrs[i]);
  endtask

  task automatic test_partial();
    int unsigned addr;
    for (int i = 0; i < 8; i++) begin
      addr = $urandom % NumWords;
      do_write(addr, $urandom, 4'($urandom % 15)); // Never all four bytes
      read_expect(addr);
    end
  endtask

  task automatic test_single_flip();
    int unsigned          addr;
    logic [DataWidth-1:0] data;
    logic                 single, multi, gnt_next;
    for (int i = 0; i < 4; i++) begin
      addr = $urandom % NumWords;
      do_write(addr, $urandom, 4'hF);
      inject_flip(addr, $urandom % CodeWidth);
      do_read(addr, data, single, multi, gnt_next);
      check_val("rdata_o", data, model_word(addr));
      check_val("single_error_o", single, 1);
      check_val("multi_error_o", multi, 0);
      check_val("gnt_o", gnt_next, 0); // Write-back cycle
      step();
      check_val("gnt_o", gnt_o, 1);
      read_expect(addr); // Clean now, so the fix reached the bank
    end
  endtask

  task automatic test_double_flip();
    int unsigned          addr, b0, b1;
    logic [DataWidth-1:0] data;
    logic                 single, multi, gnt_next;
    addr = $urandom % NumWords;
    b0   = $urandom % CodeWidth;
    b1   = (b0 + 1 + $urandom % (CodeWidth - 1)) % CodeWidth;
    do_write(addr, $urandom, 4'hF);
    inject_flip(addr, b0);
    inject_flip(addr, b1);
    do_read(addr, data, single, multi, gnt_next);
    check_val("multi_error_o", multi, 1);
    check_val("single_error_o", single, 0);
    check_val("gnt_o", gnt_next, 1);
    do_write(addr, $urandom, 4'hF); // Leave a clean word behind
  endtask

  task automatic test_scrub();
    int unsigned base, dbl_addr, fixes, uncorr;
    int unsigned addrs [$];
    base  = $urandom % NumWords;
    fixes = 0;
    uncorr = 0;
    for (int k = 0; k < 4; k++) begin
      addrs.push_back((base + k * 37) % NumWords);
      inject_flip(addrs[k], $urandom % CodeWidth);
    end
    dbl_addr = (base + 4 * 37) % NumWords;
    inject_flip(dbl_addr, 3);
    inject_flip(dbl_addr, 35);
    scrub_trigger_i = 1'b1;
    repeat (3 * NumWords) begin
      step();
      fixes  += scrubber_fix_o;
      uncorr += scrub_uncorrectable_o;
    end
    scrub_trigger_i = 1'b0;
    step();
    step(); // Let a pending repair finish
    check_val("scrubber_fix_o pulses", fixes, addrs.size());
    if (uncorr == 0) begin
      $display("The scrubber did not report the word with two flipped bits at %0t", $time);
      errors++;
    end
    foreach (addrs[i]) read_expect(addrs[i]);
    do_write(dbl_addr, $urandom, 4'hF);
  endtask

  // Front-end traffic while the scrubber runs
  task automatic test_mixed();
    int unsigned addr;
    scrub_trigger_i = 1'b1;
    for (int i = 0; i < 48; i++) begin
      addr = $urandom % NumWords;
      case ($urandom % 3)
        0:       read_expect(addr);
        1:       do_write(addr, $urandom, 4'hF);
        default: do_write(addr, $urandom, 4'($urandom % 15));
      endcase
      if ($urandom % 2) step(); // Idle gap for the scrubber
    end
    scrub_trigger_i = 1'b0;
  endtask

  initial begin
    void'($urandom(Seed));
    errors          = 0;
    clk_i           = 1'b0;
    rst_ni          = 1'b0;
    scrub_trigger_i = 1'b0;
    req_i           = 1'b0;
    we_i            = 1'b0;
    addr_i          = '0;
    wdata_i         = '0;
    be_i            = '0;
    repeat (16) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    test_reset_and_full();
    test_partial();
    test_single_flip();
    test_double_flip();
    test_scrub();
    test_mixed();
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    #(WatchdogCycles * ClkPeriod);
    $display("Timeout: the tests did not finish within %0d cycles", WatchdogCycles);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: ecc_sram.f
design/ecc_sram_pkg.sv
design/secded_enc.sv
design/secded_dec.sv
design/ecc_scrubber.sv
design/sram_bank.sv
design/ecc_sram.sv
dv/tb_ecc_sram.sv

// File: Bender.yml
package:
  name: ecc_sram

sources:
  - design/ecc_sram_pkg.sv
  - design/secded_enc.sv
  - design/secded_dec.sv
  - design/ecc_scrubber.sv
  - design/sram_bank.sv
  - design/ecc_sram.sv
  - target: test
    files:
      - dv/tb_ecc_sram.sv
